/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = nes_io_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* files.f */
+incdir+testbench
hdl/nes_input_pkg.sv
hdl/nes_memory_pkg.sv
hdl/controller_ports.sv
hdl/palette_loader.sv
hdl/reset_sequencer.sv
hdl/save_ram_clearer.sv
hdl/save_ram.sv
hdl/nes_io_top.sv
testbench/nes_io_tb.sv

/* hdl/controller_ports.sv */
module controller_ports
  import nes_input_pkg::*;
(
  input  logic                clk_ppu_21_47,
  input  logic                reset_nes,

  input  logic [pad_bits-1:0] p1_pad,
  input  logic [pad_bits-1:0] p2_pad,
  input  logic [pad_bits-1:0] p3_pad,
  input  logic [pad_bits-1:0] p4_pad,

  input  logic                multitap_enabled,
  input  logic                swap_controllers,

  input  logic                joypad_strobe,
  input  logic [1:0]          joypad_clock,

  output logic                joypad1_data,
  output logic                joypad2_data
);

  logic [port_frame_bits-1:0] port1_frame;
  logic [port_frame_bits-1:0] port2_frame;
  logic [1:0]                 last_joypad_clock;

  logic [port_frame_bits-1:0] port1_load;
  logic [port_frame_bits-1:0] port2_load;
  logic [1:0]                 clock_fall;

  // frames as seen by the console after a strobe
  always_comb begin
    port1_load = {
      multitap_enabled ? {multitap_sig_port1, p3_pad} : no_tap_fill,
      swap_controllers ? p2_pad : p1_pad
    };
    port2_load = {
      multitap_enabled ? {multitap_sig_port2, p4_pad} : no_tap_fill,
      swap_controllers ? p1_pad : p2_pad
    };
  end

  assign clock_fall = last_joypad_clock & ~joypad_clock;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      port1_frame       <= '0;
      port2_frame       <= '0;
      last_joypad_clock <= '0;
    end else begin
      last_joypad_clock <= joypad_clock;

      // reload every cycle while the strobe is held
      if (joypad_strobe) begin
        port1_frame <= port1_load;
        port2_frame <= port2_load;
      end

      // a falling clock moves the next bit into place, zeros behind it
      if (clock_fall[0]) begin
        port1_frame <= {1'b0, port1_frame[port_frame_bits-1:1]};
      end
      if (clock_fall[1]) begin
        port2_frame <= {1'b0, port2_frame[port_frame_bits-1:1]};
      end
    end
  end

  assign joypad1_data = port1_frame[0];
  assign joypad2_data = port2_frame[0];

endmodule

/* hdl/nes_input_pkg.sv */
package nes_input_pkg;

  // one pad, bit order from lsb:
  // a, b, select, start, up, down, left, right
  localparam int pad_bits = 8;

  // serial frame per port
  // {signature, far pad, near pad}, near pad goes out first
  localparam int port_frame_bits = 24;

  // four score ids, shifted after the two pads
  localparam logic [7:0] multitap_sig_port1 = 8'h08;
  localparam logic [7:0] multitap_sig_port2 = 8'h04;

  // filler for the upper 16 bits when no multitap is attached
  localparam logic [15:0] no_tap_fill = 16'hffff;

endpackage

/* hdl/nes_io_top.sv */
module nes_io_top
  import nes_input_pkg::*;
  import nes_memory_pkg::*;
#(
  parameter int SAVE_ADDR_WIDTH       = 11,
  parameter int CLEAR_WRITE_CYCLES    = 16,
  parameter int DOWNLOAD_RESET_CYCLES = 255
) (
  input  logic                          clk_ppu_21_47,
  input  logic                          reset_nes,

  // pads and controller port options
  input  logic [pad_bits-1:0]           p1_pad,
  input  logic [pad_bits-1:0]           p2_pad,
  input  logic [pad_bits-1:0]           p3_pad,
  input  logic [pad_bits-1:0]           p4_pad,
  input  logic                          multitap_enabled,
  input  logic                          swap_controllers,
  input  logic                          joypad_strobe,
  input  logic [1:0]                    joypad_clock,
  output logic                          joypad1_data,
  output logic                          joypad2_data,

  // download stream
  input  logic                          ioctl_wr,
  input  logic [7:0]                    ioctl_addr,
  input  logic [7:0]                    ioctl_dout,
  input  logic                          ioctl_download,
  input  logic                          palette_download,
  input  logic                          is_downloading,

  output logic [color_bits-1:0]         palette_color,
  output logic [palette_index_bits-1:0] palette_index,
  output logic                          palette_color_write,

  // reset control
  input  logic                          loader_busy,
  input  logic                          loader_fail,
  input  logic                          external_reset,
  output logic                          console_reset,
  output logic                          loader_reset,
  output logic                          clearing,

  // mapper save port
  input  logic [SAVE_ADDR_WIDTH-1:0]    bram_addr,
  input  logic [save_data_bits-1:0]     bram_wdata,
  input  logic                          bram_write,
  output logic [save_data_bits-1:0]     bram_rdata,

  // sd buffer save port
  input  logic [SAVE_ADDR_WIDTH-1:0]    sd_buff_addr,
  input  logic [save_data_bits-1:0]     sd_buff_wdata,
  input  logic                          sd_buff_wr,
  output logic [save_data_bits-1:0]     sd_buff_rdata
);

  logic [SAVE_ADDR_WIDTH-1:0] clear_addr;
  logic                       clear_write;

  controller_ports controller_ports_inst (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .p1_pad           (p1_pad),
    .p2_pad           (p2_pad),
    .p3_pad           (p3_pad),
    .p4_pad           (p4_pad),
    .multitap_enabled (multitap_enabled),
    .swap_controllers (swap_controllers),
    .joypad_strobe    (joypad_strobe),
    .joypad_clock     (joypad_clock),
    .joypad1_data     (joypad1_data),
    .joypad2_data     (joypad2_data)
  );

  palette_loader palette_loader_inst (
    .clk_ppu_21_47       (clk_ppu_21_47),
    .reset_nes           (reset_nes),
    .palette_download    (palette_download),
    .ioctl_wr            (ioctl_wr),
    .ioctl_addr          (ioctl_addr),
    .ioctl_dout          (ioctl_dout),
    .palette_color       (palette_color),
    .palette_index       (palette_index),
    .palette_color_write (palette_color_write)
  );

  // clearing also holds the console in reset
  reset_sequencer #(
    .DOWNLOAD_RESET_CYCLES (DOWNLOAD_RESET_CYCLES)
  ) reset_sequencer_inst (
    .clk_ppu_21_47  (clk_ppu_21_47),
    .reset_nes      (reset_nes),
    .download       (ioctl_download),
    .loader_busy    (loader_busy),
    .loader_fail    (loader_fail),
    .external_reset (external_reset),
    .clearing       (clearing),
    .console_reset  (console_reset),
    .loader_reset   (loader_reset)
  );

  save_ram_clearer #(
    .SAVE_ADDR_WIDTH    (SAVE_ADDR_WIDTH),
    .CLEAR_WRITE_CYCLES (CLEAR_WRITE_CYCLES)
  ) save_ram_clearer_inst (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .is_downloading   (is_downloading),
    .palette_download (palette_download),
    .sd_buff_wr       (sd_buff_wr),
    .clearing         (clearing),
    .clear_addr       (clear_addr),
    .clear_write      (clear_write)
  );

  save_ram #(
    .SAVE_ADDR_WIDTH (SAVE_ADDR_WIDTH)
  ) save_ram_inst (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .clearing      (clearing),
    .clear_addr    (clear_addr),
    .clear_write   (clear_write),
    .bram_addr     (bram_addr),
    .bram_wdata    (bram_wdata),
    .bram_write    (bram_write),
    .bram_rdata    (bram_rdata),
    .sd_buff_addr  (sd_buff_addr),
    .sd_buff_wdata (sd_buff_wdata),
    .sd_buff_wr    (sd_buff_wr),
    .sd_buff_rdata (sd_buff_rdata)
  );

endmodule

/* hdl/nes_memory_pkg.sv */
package nes_memory_pkg;

  // palette table
  localparam int palette_entries = 64;
  localparam int palette_index_bits = $clog2(palette_entries);

  // one rgb triple, red in the top byte
  localparam int color_bits = 24;

  // 64 entries of 3 bytes; anything past this in the download is ignored
  localparam int palette_bytes = 192;

  // save ram word
  localparam int save_data_bits = 8;

endpackage

/* hdl/palette_loader.sv */
module palette_loader
  import nes_memory_pkg::*;
(
  input  logic                          clk_ppu_21_47,
  input  logic                          reset_nes,

  input  logic                          palette_download,
  input  logic                          ioctl_wr,
  input  logic [7:0]                    ioctl_addr,
  input  logic [7:0]                    ioctl_dout,

  output logic [color_bits-1:0]         palette_color,
  output logic [palette_index_bits-1:0] palette_index,
  output logic                          palette_color_write
);

  logic [1:0] byte_count;
  logic       byte_taken;

  assign byte_taken = palette_download && ioctl_wr && (ioctl_addr < 8'(palette_bytes));

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes || !palette_download) begin
      byte_count    <= 2'd0;
      palette_index <= '0;
    end else if (byte_taken) begin
      byte_count <= (byte_count == 2'd2) ? 2'd0 : byte_count + 2'd1;
      // first byte of a triple opens the next entry, except at the very start
      if (byte_count == 2'd0 && ioctl_addr != 8'd0) begin
        palette_index <= palette_index + 1'b1;
      end
    end
  end

  // red, green, blue in download order
  always_ff @(posedge clk_ppu_21_47) begin
    if (byte_taken) begin
      case (byte_count)
        2'd0:    palette_color[23:16] <= ioctl_dout;
        2'd1:    palette_color[15:8]  <= ioctl_dout;
        default: palette_color[7:0]   <= ioctl_dout;
      endcase
    end
  end

  // high between triples, i.e. once all three bytes of an entry are in
  assign palette_color_write = palette_download && (byte_count == 2'd0);

endmodule

/* hdl/reset_sequencer.sv */
module reset_sequencer #(
  parameter int DOWNLOAD_RESET_CYCLES = 255
) (
  input  logic clk_ppu_21_47,
  input  logic reset_nes,

  input  logic download,
  input  logic loader_busy,
  input  logic loader_fail,
  input  logic external_reset,
  input  logic clearing,

  output logic console_reset,
  output logic loader_reset
);

  localparam int count_bits = $clog2(DOWNLOAD_RESET_CYCLES + 1);

  logic                  ever_downloaded;
  logic                  download_d;
  logic [count_bits-1:0] download_count;
  logic                  download_hold;

  assign download_hold = download_count != '0;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      ever_downloaded <= 1'b0;
      download_d      <= 1'b0;
      download_count  <= '0;
      loader_reset    <= 1'b1;
    end else begin
      download_d <= download;

      // console stays dead until something has been loaded
      if (download) begin
        ever_downloaded <= 1'b1;
      end

      // countdown starts once the download ends, stalls while the loader works
      if (download) begin
        download_count <= count_bits'(DOWNLOAD_RESET_CYCLES);
      end else if (!loader_busy && download_hold) begin
        download_count <= download_count - 1'b1;
      end

      // new download starts the loader over
      loader_reset <= !download_hold || (download && !download_d);
    end
  end

  assign console_reset = !ever_downloaded || download_hold || loader_fail ||
                         external_reset || clearing;

endmodule

/* hdl/save_ram.sv */
module save_ram
  import nes_memory_pkg::*;
#(
  parameter int SAVE_ADDR_WIDTH = 11
) (
  input  logic                       clk_ppu_21_47,

  // clearer takes over port a
  input  logic                       clearing,
  input  logic [SAVE_ADDR_WIDTH-1:0] clear_addr,
  input  logic                       clear_write,

  // port a, mapper side
  input  logic [SAVE_ADDR_WIDTH-1:0] bram_addr,
  input  logic [save_data_bits-1:0]  bram_wdata,
  input  logic                       bram_write,
  output logic [save_data_bits-1:0]  bram_rdata,

  // port b, sd buffer side
  input  logic [SAVE_ADDR_WIDTH-1:0] sd_buff_addr,
  input  logic [save_data_bits-1:0]  sd_buff_wdata,
  input  logic                       sd_buff_wr,
  output logic [save_data_bits-1:0]  sd_buff_rdata
);

  logic [save_data_bits-1:0]  mem [2**SAVE_ADDR_WIDTH];

  logic [SAVE_ADDR_WIDTH-1:0] addr_a;
  logic [save_data_bits-1:0]  wdata_a;
  logic                       write_a;

  assign addr_a  = clearing ? clear_addr : bram_addr;
  assign wdata_a = clearing ? '0 : bram_wdata;
  assign write_a = clearing ? clear_write : bram_write;

  always_ff @(posedge clk_ppu_21_47) begin
    if (write_a) begin
      mem[addr_a] <= wdata_a;
    end
    if (sd_buff_wr) begin
      mem[sd_buff_addr] <= sd_buff_wdata;
    end
    bram_rdata    <= mem[addr_a];
    sd_buff_rdata <= mem[sd_buff_addr];
  end

endmodule

/* hdl/save_ram_clearer.sv */
module save_ram_clearer #(
  parameter int SAVE_ADDR_WIDTH    = 11,
  parameter int CLEAR_WRITE_CYCLES = 16
) (
  input  logic                       clk_ppu_21_47,
  input  logic                       reset_nes,

  input  logic                       is_downloading,
  input  logic                       palette_download,
  input  logic                       sd_buff_wr,

  output logic                       clearing,
  output logic [SAVE_ADDR_WIDTH-1:0] clear_addr,
  output logic                       clear_write
);

  localparam int div_bits = (CLEAR_WRITE_CYCLES > 1) ? $clog2(CLEAR_WRITE_CYCLES) : 1;
  localparam logic [div_bits-1:0] div_start = div_bits'(CLEAR_WRITE_CYCLES - 1);

  logic                save_loaded;
  logic                prev_is_downloading;
  logic                prev_palette_download;
  logic [div_bits-1:0] clear_div;
  logic                start_clear;

  // assets done, nothing restored from sd, and not just a palette swap
  assign start_clear = prev_is_downloading && !is_downloading &&
                       !save_loaded && !prev_palette_download && !clearing;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      save_loaded           <= 1'b0;
      prev_is_downloading   <= 1'b0;
      prev_palette_download <= 1'b0;
      clearing              <= 1'b0;
      clear_write           <= 1'b0;
      clear_addr            <= '0;
      clear_div             <= '0;
    end else begin
      prev_is_downloading   <= is_downloading;
      prev_palette_download <= palette_download;

      if (sd_buff_wr) begin
        save_loaded <= 1'b1;
      end

      if (start_clear) begin
        clearing    <= 1'b1;
        clear_write <= 1'b1;
        clear_addr  <= '0;
        clear_div   <= div_start;
      end else if (clearing) begin
        if (clear_write) begin
          // hold the strobe for the full write window
          if (clear_div == '0) begin
            clear_write <= 1'b0;
          end else begin
            clear_div <= clear_div - 1'b1;
          end
        end else if (&clear_addr) begin
          clearing <= 1'b0;
        end else begin
          // idle cycle done, on to the next word
          clear_addr  <= clear_addr + 1'b1;
          clear_write <= 1'b1;
          clear_div   <= div_start;
        end
      end
    end
  end

endmodule

/* testbench/nes_io_tests.svh */
// strobe and clock both ports out bit by bit against the model frames
task automatic shift_and_compare(input logic [23:0] frame1, input logic [23:0] frame2);
  logic [23:0] model1;
  logic [23:0] model2;
  model1 = frame1;
  model2 = frame2;
  joypad_strobe = 1'b1;
  step_cycles(1);
  joypad_strobe = 1'b0;
  step_cycles(1);
  // 25 looks with the last one after all 24 bits are gone
  for (int i = 0; i <= 24; i++) begin
    check_value($sformatf("joypad1_data bit %0d", i), 32'(joypad1_data), 32'(model1[0]));
    check_value($sformatf("joypad2_data bit %0d", i), 32'(joypad2_data), 32'(model2[0]));
    joypad_clock = 2'b11;
    step_cycles(1);
    joypad_clock = 2'b00;
    step_cycles(2);
    model1 = {1'b0, model1[23:1]};
    model2 = {1'b0, model2[23:1]};
  end
endtask

task automatic controller_serial_order();
  p1_pad = random_byte();
  p2_pad = random_byte();
  p3_pad = random_byte();
  p4_pad = random_byte();
  multitap_enabled = 1'b1;
  swap_controllers = 1'b0;
  // four score signatures on top and the near pad shifted first
  shift_and_compare({8'h08, p3_pad, p1_pad}, {8'h04, p4_pad, p2_pad});
endtask

task automatic swap_and_fill();
  p1_pad = random_byte();
  p2_pad = random_byte();
  p3_pad = random_byte();
  p4_pad = random_byte();
  multitap_enabled = 1'b0;
  swap_controllers = 1'b1;
  shift_and_compare({16'hffff, p2_pad}, {16'hffff, p1_pad});
endtask

task automatic send_palette_byte(input logic [7:0] addr, input logic [7:0] data);
  ioctl_addr = addr;
  ioctl_dout = data;
  ioctl_wr   = 1'b1;
  step_cycles(1);
  ioctl_wr   = 1'b0;
  step_cycles(1);
endtask

task automatic palette_assembly();
  logic [7:0]  rgb [3];
  logic [23:0] last_color;
  palette_download = 1'b1;
  step_cycles(1);
  for (int t = 0; t < 6; t++) begin
    for (int b = 0; b < 3; b++) begin
      rgb[b] = random_byte();
      send_palette_byte(8'(t * 3 + b), rgb[b]);
      if (b == 0) begin
        check_value("palette_color_write", 32'(palette_color_write), 32'd0);
      end
    end
    check_value("palette_color_write", 32'(palette_color_write), 32'd1);
    check_value("palette_color", 32'(palette_color), 32'({rgb[0], rgb[1], rgb[2]}));
    check_value("palette_index", 32'(palette_index), 32'(t));
  end
  last_color = {rgb[0], rgb[1], rgb[2]};
  // past the 64-entry table
  send_palette_byte(8'd192, 8'h5a);
  send_palette_byte(8'd255, 8'ha5);
  check_value("palette_color", 32'(palette_color), 32'(last_color));
  check_value("palette_index", 32'(palette_index), 32'd5);
  check_value("palette_color_write", 32'(palette_color_write), 32'd1);
  palette_download = 1'b0;
  step_cycles(1);
  check_value("palette_color_write", 32'(palette_color_write), 32'd0);
endtask

task automatic reset_sequencing();
  int held;
  check_value("console_reset", 32'(console_reset), 32'd1);
  ioctl_download = 1'b1;
  step_cycles(4);
  check_value("console_reset", 32'(console_reset), 32'd1);
  check_value("loader_reset", 32'(loader_reset), 32'd0);
  ioctl_download = 1'b0;
  // a busy loader must stall the countdown
  loader_busy = 1'b1;
  step_cycles(20);
  check_value("console_reset", 32'(console_reset), 32'd1);
  check_value("loader_reset", 32'(loader_reset), 32'd0);
  // another download in the middle of the countdown restarts the loader
  ioctl_download = 1'b1;
  step_cycles(1);
  check_value("loader_reset", 32'(loader_reset), 32'd1);
  ioctl_download = 1'b0;
  step_cycles(1);
  check_value("loader_reset", 32'(loader_reset), 32'd0);
  loader_busy = 1'b0;
  held = 0;
  while (console_reset) begin
    held++;
    if (held > 4 * download_reset_cycles) begin
      stop_with_failure("console_reset was never released after the download ended");
    end
    step_cycles(1);
  end
  if (held < download_reset_cycles) begin
    stop_with_failure($sformatf("console_reset released after only %0d cycles", held));
  end
  step_cycles(1);
  check_value("loader_reset", 32'(loader_reset), 32'd1);
  loader_fail = 1'b1;
  step_cycles(1);
  check_value("console_reset", 32'(console_reset), 32'd1);
  loader_fail = 1'b0;
  step_cycles(1);
  check_value("console_reset", 32'(console_reset), 32'd0);
  external_reset = 1'b1;
  step_cycles(1);
  check_value("console_reset", 32'(console_reset), 32'd1);
  external_reset = 1'b0;
  step_cycles(1);
  check_value("console_reset", 32'(console_reset), 32'd0);
endtask

task automatic save_ram_clear();
  int         cycles;
  logic [7:0] last_data;
  bram_write = 1'b1;
  for (int a = 0; a < save_words; a++) begin
    bram_addr  = save_addr_width'(a);
    last_data  = random_byte() | 8'h01;
    bram_wdata = last_data;
    step_cycles(1);
  end
  bram_write = 1'b0;
  step_cycles(1);
  check_value("bram_rdata", 32'(bram_rdata), 32'(last_data));
  is_downloading = 1'b1;
  step_cycles(1);
  is_downloading = 1'b0;
  cycles = 0;
  while (!clearing && cycles < 4) begin
    cycles++;
    step_cycles(1);
  end
  if (!clearing) begin
    stop_with_failure("clearing did not start after is_downloading fell");
  end
  cycles = 0;
  while (clearing) begin
    check_value("console_reset", 32'(console_reset), 32'd1);
    cycles++;
    step_cycles(1);
  end
  check_value("clearing cycles", 32'(cycles), 32'(clear_cycles));
  for (int a = 0; a < save_words; a++) begin
    bram_addr    = save_addr_width'(a);
    sd_buff_addr = save_addr_width'(a);
    step_cycles(1);
    check_value($sformatf("bram_rdata[%0d]", a), 32'(bram_rdata), 32'd0);
    check_value($sformatf("sd_buff_rdata[%0d]", a), 32'(sd_buff_rdata), 32'd0);
  end
endtask

task automatic save_kept();
  logic [7:0] saved [16];
  int         base;
  base = 4 * int'(random_byte());
  sd_buff_wr = 1'b1;
  for (int i = 0; i < 16; i++) begin
    saved[i]      = random_byte();
    sd_buff_addr  = save_addr_width'(base + i);
    sd_buff_wdata = saved[i];
    step_cycles(1);
  end
  sd_buff_wr = 1'b0;
  is_downloading = 1'b1;
  step_cycles(1);
  is_downloading = 1'b0;
  repeat (clear_write_cycles + 4) begin
    step_cycles(1);
    check_value("clearing", 32'(clearing), 32'd0);
  end
  for (int i = 0; i < 16; i++) begin
    bram_addr = save_addr_width'(base + i);
    step_cycles(1);
    check_value($sformatf("bram_rdata[%0d]", base + i), 32'(bram_rdata), 32'(saved[i]));
  end
endtask

/* testbench/nes_io_tb.sv */
module nes_io_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int save_addr_width       = 11;
  localparam int clear_write_cycles    = 16;
  localparam int download_reset_cycles = 255;
  localparam int save_words            = 2 ** save_addr_width;
  localparam int clear_cycles          = save_words * (clear_write_cycles + 1);
  // the clear plus fill and readback of the whole ram, other tests are short
  localparam int test_cycles           = clear_cycles + 3 * save_words + 1000;
  localparam int timeout_cycles        = test_cycles + 40000;

  logic                       clk_ppu_21_47;
  logic                       reset_nes;
  logic [7:0]                 p1_pad;
  logic [7:0]                 p2_pad;
  logic [7:0]                 p3_pad;
  logic [7:0]                 p4_pad;
  logic                       multitap_enabled;
  logic                       swap_controllers;
  logic                       joypad_strobe;
  logic [1:0]                 joypad_clock;
  logic                       joypad1_data;
  logic                       joypad2_data;
  logic                       ioctl_wr;
  logic [7:0]                 ioctl_addr;
  logic [7:0]                 ioctl_dout;
  logic                       ioctl_download;
  logic                       palette_download;
  logic                       is_downloading;
  logic [23:0]                palette_color;
  logic [5:0]                 palette_index;
  logic                       palette_color_write;
  logic                       loader_busy;
  logic                       loader_fail;
  logic                       external_reset;
  logic                       console_reset;
  logic                       loader_reset;
  logic                       clearing;
  logic [save_addr_width-1:0] bram_addr;
  logic [7:0]                 bram_wdata;
  logic                       bram_write;
  logic [7:0]                 bram_rdata;
  logic [save_addr_width-1:0] sd_buff_addr;
  logic [7:0]                 sd_buff_wdata;
  logic                       sd_buff_wr;
  logic [7:0]                 sd_buff_rdata;

  logic [31:0] rng_state = 32'h2dbd_f38c;
  int          cycle_count = 0;

  nes_io_top #(
    .SAVE_ADDR_WIDTH       (save_addr_width),
    .CLEAR_WRITE_CYCLES    (clear_write_cycles),
    .DOWNLOAD_RESET_CYCLES (download_reset_cycles)
  ) nes_io_top_inst (.*);

  initial begin
    clk_ppu_21_47 = 1'b0;
    forever #10 clk_ppu_21_47 = ~clk_ppu_21_47;
  end

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h",
                                  name, actual, expected));
    end
  endtask

  always @(posedge clk_ppu_21_47) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      stop_with_failure($sformatf("timeout: tests still running after %0d cycles",
                                  timeout_cycles));
    end
  end

  // inputs change 1 ns after the rising edge
  task automatic step_cycles(input int n);
    repeat (n) @(posedge clk_ppu_21_47);
    #1;
  endtask

  // lcg, numerical recipes constants
  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic [7:0] random_byte();
    logic [31:0] r;
    r = next_random();
    return r[23:16];
  endfunction

  `include "nes_io_tests.svh"

  initial begin
    reset_nes        = 1'b1;
    p1_pad           = '0;
    p2_pad           = '0;
    p3_pad           = '0;
    p4_pad           = '0;
    multitap_enabled = 1'b0;
    swap_controllers = 1'b0;
    joypad_strobe    = 1'b0;
    joypad_clock     = 2'b00;
    ioctl_wr         = 1'b0;
    ioctl_addr       = '0;
    ioctl_dout       = '0;
    ioctl_download   = 1'b0;
    palette_download = 1'b0;
    is_downloading   = 1'b0;
    loader_busy      = 1'b0;
    loader_fail      = 1'b0;
    external_reset   = 1'b0;
    bram_addr        = '0;
    bram_wdata       = '0;
    bram_write       = 1'b0;
    sd_buff_addr     = '0;
    sd_buff_wdata    = '0;
    sd_buff_wr       = 1'b0;
    step_cycles(10);
    reset_nes = 1'b0;
    step_cycles(2);

    controller_serial_order();
    swap_and_fill();
    palette_assembly();
    reset_sequencing();
    save_ram_clear();
    save_kept();

    $display("NO ERRORS");
    $finish;
  end

endmodule
